// ==== sim.f ====
source/fetch_pkg.sv
source/next_line_prefetcher.sv
source/prefetch_regs.sv
source/icache.sv
source/mem_arbiter.sv
source/fetch_subsystem.sv
verif/mem_model.sv
verif/fetch_tb.sv

// ==== source/fetch_pkg.sv ====
package fetch_pkg;

    // cache line geometry
    localparam int line_bits   = 256;
    localparam int line_bytes  = line_bits / 8;
    localparam int offset_bits = $clog2(line_bytes);

    // direct-mapped organisation
    localparam int num_sets   = 8;
    localparam int index_bits = $clog2(num_sets);
    localparam int tag_bits   = 32 - index_bits - offset_bits;

    // register map of the prefetch control block
    localparam logic [1:0] reg_ctrl           = 2'd0;
    localparam logic [1:0] reg_demand_count   = 2'd1;
    localparam logic [1:0] reg_prefetch_count = 2'd2;

    typedef logic [line_bits-1:0] line_t;

    // line request toward memory with a line-aligned address
    typedef struct packed {
        logic        read;
        logic [31:0] address;
    } mem_req_t;

    // one-cycle start pulses for the statistics counters
    typedef struct packed {
        logic demand_start;
        logic prefetch_start;
    } fetch_stats_t;

endpackage

// ==== source/fetch_subsystem.sv ====
`timescale 1ns/100ps

module fetch_subsystem (
    input  logic                clk,
    input  logic                rst,
    // cpu fetch port
    input  logic [31:0]         imem_address,
    input  logic                imem_read,
    output fetch_pkg::line_t    imem_rdata,
    output logic                imem_resp,
    input  logic                branch_taken,
    // data read port
    input  logic                dmem_read,
    input  logic [31:0]         dmem_address,
    output fetch_pkg::line_t    dmem_rdata,
    output logic                dmem_resp,
    // register port
    input  logic                cfg_write,
    input  logic [1:0]          cfg_addr,
    input  logic [31:0]         cfg_wdata,
    output logic [31:0]         cfg_rdata,
    // memory port
    output fetch_pkg::mem_req_t mem_req,
    input  logic                mem_resp,
    input  fetch_pkg::line_t    mem_rdata
);

    logic [31:0]             icmem_address;
    logic                    icmem_read;
    fetch_pkg::line_t        icmem_rdata;
    logic                    icmem_resp;
    fetch_pkg::mem_req_t     fill_req;
    logic                    fill_resp;
    fetch_pkg::line_t        fill_rdata;
    logic                    arbiter_idle;
    logic                    prefetch_enable;
    fetch_pkg::fetch_stats_t stats;

    next_line_prefetcher i_next_line_prefetcher (
        .clk             (clk),
        .rst             (rst),
        .imem_address    (imem_address),
        .imem_read       (imem_read),
        .imem_rdata      (imem_rdata),
        .imem_resp       (imem_resp),
        .icmem_rdata     (icmem_rdata),
        .icmem_resp      (icmem_resp),
        .icmem_address   (icmem_address),
        .icmem_read      (icmem_read),
        .branch_taken    (branch_taken),
        .arbiter_idle    (arbiter_idle),
        .prefetch_enable (prefetch_enable),
        .stats           (stats)
    );

    prefetch_regs i_prefetch_regs (
        .clk             (clk),
        .rst             (rst),
        .cfg_write       (cfg_write),
        .cfg_addr        (cfg_addr),
        .cfg_wdata       (cfg_wdata),
        .cfg_rdata       (cfg_rdata),
        .stats           (stats),
        .prefetch_enable (prefetch_enable)
    );

    icache i_icache (
        .clk           (clk),
        .rst           (rst),
        .icmem_address (icmem_address),
        .icmem_read    (icmem_read),
        .icmem_rdata   (icmem_rdata),
        .icmem_resp    (icmem_resp),
        .fill_req      (fill_req),
        .fill_resp     (fill_resp),
        .fill_rdata    (fill_rdata)
    );

    mem_arbiter i_mem_arbiter (
        .clk          (clk),
        .rst          (rst),
        .fill_req     (fill_req),
        .fill_resp    (fill_resp),
        .fill_rdata   (fill_rdata),
        .dmem_read    (dmem_read),
        .dmem_address (dmem_address),
        .dmem_rdata   (dmem_rdata),
        .dmem_resp    (dmem_resp),
        .mem_req      (mem_req),
        .mem_resp     (mem_resp),
        .mem_rdata    (mem_rdata),
        .arbiter_idle (arbiter_idle)
    );

endmodule

// ==== source/icache.sv ====
`timescale 1ns/100ps

module icache (
    input  logic                clk,
    input  logic                rst,
    input  logic [31:0]         icmem_address,
    input  logic                icmem_read,
    output fetch_pkg::line_t    icmem_rdata,
    output logic                icmem_resp,
    output fetch_pkg::mem_req_t fill_req,
    input  logic                fill_resp,
    input  fetch_pkg::line_t    fill_rdata
);

    typedef enum logic [1:0] {
        idle,
        lookup,
        fill,
        respond
    } state_t;

    state_t state, next_state;

    logic [31:0] addr_q;

    // line storage
    logic [fetch_pkg::num_sets-1:0] valid_q;
    logic [fetch_pkg::tag_bits-1:0] tag_q [fetch_pkg::num_sets];
    fetch_pkg::line_t               data_q [fetch_pkg::num_sets];

    logic [fetch_pkg::index_bits-1:0] index;
    logic [fetch_pkg::tag_bits-1:0]   tag;
    logic                             hit;

    assign index = addr_q[fetch_pkg::offset_bits +: fetch_pkg::index_bits];
    assign tag   = addr_q[31 -: fetch_pkg::tag_bits];
    assign hit   = valid_q[index] && (tag_q[index] == tag);

    always_comb begin
        next_state = state;
        case (state)
            idle: begin
                if (icmem_read) next_state = lookup;
            end
            lookup: begin
                if (hit) begin
                    next_state = idle;
                end else begin
                    next_state = fill;
                end
            end
            fill: begin
                if (fill_resp) next_state = respond;
            end
            respond: next_state = idle;
            default: next_state = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    // request address captured as the lookup starts
    always_ff @(posedge clk) begin
        if (state == idle && icmem_read) begin
            addr_q <= icmem_address;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (state == fill && fill_resp) begin
            valid_q[index] <= 1'b1;
        end
    end

    // tag and line written together when the fill returns
    always_ff @(posedge clk) begin
        if (state == fill && fill_resp) begin
            tag_q[index]  <= tag;
            data_q[index] <= fill_rdata;
        end
    end

    // hit answers from lookup and a miss one cycle after the fill
    assign icmem_resp  = (state == lookup && hit) || (state == respond);
    assign icmem_rdata = data_q[index];

    assign fill_req = '{
        read:    (state == fill),
        address: {addr_q[31:fetch_pkg::offset_bits], {fetch_pkg::offset_bits{1'b0}}}
    };

endmodule

// ==== source/mem_arbiter.sv ====
`timescale 1ns/100ps

module mem_arbiter (
    input  logic                clk,
    input  logic                rst,
    // cache fill side
    input  fetch_pkg::mem_req_t fill_req,
    output logic                fill_resp,
    output fetch_pkg::line_t    fill_rdata,
    // data read side
    input  logic                dmem_read,
    input  logic [31:0]         dmem_address,
    output fetch_pkg::line_t    dmem_rdata,
    output logic                dmem_resp,
    // toward memory
    output fetch_pkg::mem_req_t mem_req,
    input  logic                mem_resp,
    input  fetch_pkg::line_t    mem_rdata,
    output logic                arbiter_idle
);

    typedef enum logic [1:0] {
        owner_none,
        owner_fill,
        owner_data
    } owner_t;

    owner_t      owner;
    logic [31:0] addr_q;

    // grant only from idle, data port has priority
    always_ff @(posedge clk) begin
        if (rst) begin
            owner <= owner_none;
        end else begin
            case (owner)
                owner_none: begin
                    if (dmem_read) begin
                        owner <= owner_data;
                    end else if (fill_req.read) begin
                        owner <= owner_fill;
                    end
                end
                default: begin
                    if (mem_resp) owner <= owner_none;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (owner == owner_none) begin
            if (dmem_read) begin
                addr_q <= dmem_address;
            end else if (fill_req.read) begin
                addr_q <= fill_req.address;
            end
        end
    end

    assign mem_req = '{read: (owner != owner_none), address: addr_q};

    // return path steered to whoever holds the grant
    assign fill_resp  = mem_resp && (owner == owner_fill);
    assign dmem_resp  = mem_resp && (owner == owner_data);
    assign fill_rdata = mem_rdata;
    assign dmem_rdata = mem_rdata;

    assign arbiter_idle = (owner == owner_none) && !fill_req.read && !dmem_read;

endmodule

// ==== source/next_line_prefetcher.sv ====
`timescale 1ns/100ps

module next_line_prefetcher (
    input  logic                    clk,
    input  logic                    rst,
    // cpu fetch port
    input  logic [31:0]             imem_address,
    input  logic                    imem_read,
    output fetch_pkg::line_t        imem_rdata,
    output logic                    imem_resp,
    // toward the instruction cache
    input  fetch_pkg::line_t        icmem_rdata,
    input  logic                    icmem_resp,
    output logic [31:0]             icmem_address,
    output logic                    icmem_read,
    input  logic                    branch_taken,
    input  logic                    arbiter_idle,
    input  logic                    prefetch_enable,
    output fetch_pkg::fetch_stats_t stats
);

    typedef enum logic [1:0] {
        idle,
        serve,
        prefetch
    } state_t;

    state_t state, next_state;

    logic [31:0] last_line;
    logic [31:0] last_pf_line;
    logic        last_pf_valid;
    logic        inhibit;
    logic [31:0] demand_line;
    logic [31:0] pf_address;
    logic        repeat_line;
    logic        demand_go;
    logic        prefetch_go;

    assign demand_line = {imem_address[31:fetch_pkg::offset_bits],
                          {fetch_pkg::offset_bits{1'b0}}};

    // next-line target
    assign pf_address = last_line + fetch_pkg::line_bytes;

    // this line was already prefetched once
    assign repeat_line = last_pf_valid && (pf_address == last_pf_line);

    assign demand_go   = (state == idle) && imem_read;
    assign prefetch_go = (state == idle) && !imem_read && prefetch_enable && arbiter_idle &&
                         !inhibit && !repeat_line;

    assign stats = '{demand_start: demand_go, prefetch_start: prefetch_go};

    // the cpu only sees data of its own fetches
    assign imem_rdata = icmem_rdata;

    always_comb begin
        next_state = state;
        case (state)
            idle: begin
                if (demand_go) begin
                    next_state = serve;
                end else if (prefetch_go) begin
                    next_state = prefetch;
                end
            end
            serve: begin
                if (icmem_resp) next_state = idle;
            end
            prefetch: begin
                if (icmem_resp) next_state = idle;
            end
            default: next_state = idle;
        endcase
    end

    always_comb begin
        icmem_read    = 1'b0;
        icmem_address = imem_address;
        imem_resp     = 1'b0;
        case (state)
            idle: begin
                // start the cache read in the same cycle the decision is made
                if (demand_go) begin
                    icmem_read = 1'b1;
                end else if (prefetch_go) begin
                    icmem_read    = 1'b1;
                    icmem_address = pf_address;
                end
            end
            serve: begin
                icmem_read = 1'b1;
                imem_resp  = icmem_resp;
            end
            prefetch: begin
                // response swallowed so the cpu never sees it
                icmem_read    = 1'b1;
                icmem_address = pf_address;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= idle;
            inhibit       <= 1'b1;
            last_pf_valid <= 1'b0;
        end else begin
            state <= next_state;
            if (branch_taken || (state == prefetch && icmem_resp)) begin
                inhibit <= 1'b1;
            end else if (demand_go) begin
                inhibit <= 1'b0;
            end
            if (state == prefetch && icmem_resp) last_pf_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == serve && icmem_resp) begin
            last_line <= demand_line;
        end else if (state == prefetch && icmem_resp) begin
            last_line    <= pf_address;
            last_pf_line <= pf_address;
        end
    end

endmodule

// ==== source/prefetch_regs.sv ====
`timescale 1ns/100ps

module prefetch_regs (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cfg_write,
    input  logic [1:0]              cfg_addr,
    input  logic [31:0]             cfg_wdata,
    output logic [31:0]             cfg_rdata,
    input  fetch_pkg::fetch_stats_t stats,
    output logic                    prefetch_enable
);

    logic [31:0] demand_count;
    logic [31:0] prefetch_count;

    // enable comes up set
    always_ff @(posedge clk) begin
        if (rst) begin
            prefetch_enable <= 1'b1;
        end else if (cfg_write && cfg_addr == fetch_pkg::reg_ctrl) begin
            prefetch_enable <= cfg_wdata[0];
        end
    end

    // saturating counters cleared by any write
    always_ff @(posedge clk) begin
        if (rst) begin
            demand_count   <= '0;
            prefetch_count <= '0;
        end else begin
            if (cfg_write && cfg_addr == fetch_pkg::reg_demand_count) begin
                demand_count <= '0;
            end else if (stats.demand_start && demand_count != '1) begin
                demand_count <= demand_count + 32'd1;
            end
            if (cfg_write && cfg_addr == fetch_pkg::reg_prefetch_count) begin
                prefetch_count <= '0;
            end else if (stats.prefetch_start && prefetch_count != '1) begin
                prefetch_count <= prefetch_count + 32'd1;
            end
        end
    end

    always_comb begin
        case (cfg_addr)
            fetch_pkg::reg_ctrl:           cfg_rdata = {31'd0, prefetch_enable};
            fetch_pkg::reg_demand_count:   cfg_rdata = demand_count;
            fetch_pkg::reg_prefetch_count: cfg_rdata = prefetch_count;
            default:                       cfg_rdata = '0;
        endcase
    end

endmodule

// ==== verif/fetch_tb.sv ====
`timescale 1ns/100ps

module fetch_tb;

    localparam int num_ops    = 160;
    localparam int side_ops   = 30;
    localparam int gap_cycles = 18;
    localparam int wait_limit = 100;
    localparam int total_ops  = num_ops + 2 * side_ops + 10;
    localparam longint watchdog_ns = longint'(total_ops) * 40 * 40 + 100000;
    localparam logic [31:0] addr_mask = 32'h0000_3fff;
    localparam logic [31:0] line_mask = 32'h0000_3fe0;

    logic                clk;
    logic                rst;
    logic [31:0]         imem_address;
    logic                imem_read;
    fetch_pkg::line_t    imem_rdata;
    logic                imem_resp;
    logic                branch_taken;
    logic                dmem_read;
    logic [31:0]         dmem_address;
    fetch_pkg::line_t    dmem_rdata;
    logic                dmem_resp;
    logic                cfg_write;
    logic [1:0]          cfg_addr;
    logic [31:0]         cfg_wdata;
    logic [31:0]         cfg_rdata;
    fetch_pkg::mem_req_t mem_req;
    logic                mem_resp;
    fetch_pkg::line_t    mem_rdata;

    // reference model of the cache contents and the prefetcher
    logic        res_valid [fetch_pkg::num_sets];
    logic [31:0] res_line  [fetch_pkg::num_sets];
    logic [31:0] last_line;
    logic [31:0] last_pf_line;
    logic        last_pf_valid;
    logic        inhibit;
    logic        enable;
    int          demand_total;
    int          prefetch_total;
    logic [31:0] cur_line;

    // memory traffic seen and expected
    logic [31:0] fill_seen [$];
    logic [31:0] fill_expect [$];
    int          data_seen;
    logic        expect_quiet;

    logic [31:0] rand_state;
    int          errors;
    int          checks;
    int          test_start;

    fetch_subsystem i_fetch_subsystem (
        .clk          (clk),
        .rst          (rst),
        .imem_address (imem_address),
        .imem_read    (imem_read),
        .imem_rdata   (imem_rdata),
        .imem_resp    (imem_resp),
        .branch_taken (branch_taken),
        .dmem_read    (dmem_read),
        .dmem_address (dmem_address),
        .dmem_rdata   (dmem_rdata),
        .dmem_resp    (dmem_resp),
        .cfg_write    (cfg_write),
        .cfg_addr     (cfg_addr),
        .cfg_wdata    (cfg_wdata),
        .cfg_rdata    (cfg_rdata),
        .mem_req      (mem_req),
        .mem_resp     (mem_resp),
        .mem_rdata    (mem_rdata)
    );

    mem_model i_mem_model (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_resp  (mem_resp),
        .mem_rdata (mem_rdata)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state >> 12;
    endfunction

    function automatic logic [31:0] line_of(input logic [31:0] address);
        return {address[31:fetch_pkg::offset_bits], {fetch_pkg::offset_bits{1'b0}}};
    endfunction

    function automatic fetch_pkg::line_t expected_line(input logic [31:0] address);
        fetch_pkg::line_t line;
        logic [31:0]      base;
        base = line_of(address);
        for (int w = 0; w < fetch_pkg::line_bits / 32; w++) begin
            line[32*w +: 32] = (base + 32'(4 * w)) ^ 32'ha5a5a5a5;
        end
        return line;
    endfunction

    function automatic int set_of(input logic [31:0] line);
        return int'(line[fetch_pkg::offset_bits +: fetch_pkg::index_bits]);
    endfunction

    function automatic logic resident(input logic [31:0] line);
        return res_valid[set_of(line)] && (res_line[set_of(line)] == line);
    endfunction

    function automatic void mark_resident(input logic [31:0] line);
        res_valid[set_of(line)] = 1'b1;
        res_line[set_of(line)]  = line;
    endfunction

    task automatic check_value(input string name, input logic [255:0] got,
                               input logic [255:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("Error at %0t ns: %s", $time, what);
            errors++;
        end
    endtask

    // bus monitor sampling on the rising edge
    always @(posedge clk) begin
        if (!rst) begin
            if (mem_resp && dmem_resp) begin
                data_seen++;
            end else if (mem_resp) begin
                fill_seen.push_back(mem_req.address);
            end
            if (imem_resp) check_true(imem_read, "imem_resp pulsed with imem_read low");
            if (dmem_resp) check_true(dmem_read, "dmem_resp pulsed with dmem_read low");
            if (expect_quiet) check_true(!mem_req.read, "memory read during a cache hit");
        end
    end

    task automatic finish_fetch(input logic [31:0] address, input logic hit);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!imem_resp && cycles < wait_limit);
        check_true(imem_resp, "imem_resp never came for a demand fetch");
        if (imem_resp) begin
            check_value("imem_rdata", imem_rdata, expected_line(address));
            // count from the edge that saw the read
            if (hit) check_value("hit response cycle", cycles - 1, 1);
        end
        @(negedge clk);
        imem_read    = 1'b0;
        expect_quiet = 1'b0;
    endtask

    task automatic finish_data(input logic [31:0] address);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!dmem_resp && cycles < wait_limit);
        check_true(dmem_resp, "dmem_resp never came for a data read");
        if (dmem_resp) check_value("dmem_rdata", dmem_rdata, expected_line(address));
        @(negedge clk);
        dmem_read = 1'b0;
    endtask

    // predict the next-line prefetch and compare traffic once the ports are quiet
    task automatic settle(input int data_expect);
        logic [31:0] pf;
        pf = last_line + fetch_pkg::line_bytes;
        if (enable && !inhibit && !(last_pf_valid && pf == last_pf_line)) begin
            prefetch_total++;
            if (!resident(pf)) begin
                fill_expect.push_back(pf);
                mark_resident(pf);
            end
            last_line     = pf;
            last_pf_line  = pf;
            last_pf_valid = 1'b1;
            inhibit       = 1'b1;
        end
        repeat (gap_cycles) @(negedge clk);
        check_value("memory fill reads", fill_seen.size(), fill_expect.size());
        for (int i = 0; i < fill_expect.size() && i < fill_seen.size(); i++) begin
            check_value("fill address", fill_seen[i], fill_expect[i]);
        end
        check_value("data reads", data_seen, data_expect);
        fill_seen.delete();
        fill_expect.delete();
        data_seen = 0;
    endtask

    task automatic fetch(input logic [31:0] address, input logic jump, input logic with_data,
                         input logic [31:0] data_address);
        logic [31:0] line;
        logic        hit;
        line = line_of(address);
        hit  = resident(line);
        @(negedge clk);
        imem_address = address;
        imem_read    = 1'b1;
        branch_taken = jump;
        expect_quiet = hit && !with_data;
        if (with_data) begin
            dmem_address = data_address;
            dmem_read    = 1'b1;
        end
        fork
            finish_fetch(address, hit);
            if (with_data) finish_data(data_address);
            begin
                @(negedge clk);
                branch_taken = 1'b0;
            end
        join
        // a branch together with the demand keeps prefetching off
        demand_total++;
        inhibit = jump;
        if (!hit) begin
            fill_expect.push_back(line);
            mark_resident(line);
        end
        last_line = line;
        settle(int'(with_data));
    endtask

    task automatic data_read(input logic [31:0] address);
        @(negedge clk);
        dmem_address = address;
        dmem_read    = 1'b1;
        finish_data(address);
        settle(1);
    endtask

    task automatic write_reg(input logic [1:0] addr, input logic [31:0] value);
        @(negedge clk);
        cfg_write = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = value;
        @(negedge clk);
        cfg_write = 1'b0;
        if (addr == fetch_pkg::reg_ctrl) enable = value[0];
        if (addr == fetch_pkg::reg_demand_count) demand_total = 0;
        if (addr == fetch_pkg::reg_prefetch_count) prefetch_total = 0;
        settle(0);
    endtask

    task automatic read_reg(input logic [1:0] addr, input string name, input logic [31:0] exp);
        @(negedge clk);
        cfg_addr = addr;
        @(posedge clk);
        check_value(name, cfg_rdata, exp);
    endtask

    // mostly sequential lines with some repeats, jumps and data reads
    task automatic random_op();
        logic [31:0] kind;
        logic [31:0] offset;
        logic        with_data;
        kind      = next_random() % 10;
        offset    = next_random() % fetch_pkg::line_bytes;
        with_data = (next_random() % 4) == 0;
        if (kind < 2) begin
            data_read(next_random() & addr_mask);
        end else if (kind < 3) begin
            cur_line = next_random() & line_mask;
            fetch(cur_line + offset, 1'b1, 1'b0, '0);
        end else if (kind < 4) begin
            fetch(cur_line + offset, 1'b0, with_data, next_random() & addr_mask);
        end else begin
            cur_line = (cur_line + fetch_pkg::line_bytes) & line_mask;
            fetch(cur_line + offset, 1'b0, with_data, next_random() & addr_mask);
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s finished with %0d errors", name, errors - test_start);
        test_start = errors;
    endtask

    initial begin
        rst          = 1'b1;
        imem_address = '0;
        imem_read    = 1'b0;
        branch_taken = 1'b0;
        dmem_read    = 1'b0;
        dmem_address = '0;
        cfg_write    = 1'b0;
        cfg_addr     = '0;
        cfg_wdata    = '0;
        expect_quiet = 1'b0;
        data_seen    = 0;
        errors       = 0;
        checks       = 0;
        test_start   = 0;
        rand_state   = 32'h9df5;
        for (int s = 0; s < fetch_pkg::num_sets; s++) begin
            res_valid[s] = 1'b0;
            res_line[s]  = '0;
        end
        last_line      = '0;
        last_pf_line   = '0;
        last_pf_valid  = 1'b0;
        inhibit        = 1'b1;
        enable         = 1'b1;
        demand_total   = 0;
        prefetch_total = 0;
        cur_line       = next_random() & line_mask;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int n = 0; n < num_ops; n++) random_op();
        end_test("random_fetch_stream");

        // only demand misses and data reads may reach memory
        write_reg(fetch_pkg::reg_ctrl, 32'd0);
        for (int n = 0; n < side_ops; n++) random_op();
        write_reg(fetch_pkg::reg_ctrl, 32'd1);
        end_test("prefetch_disabled");

        write_reg(fetch_pkg::reg_demand_count, 32'd0);
        write_reg(fetch_pkg::reg_prefetch_count, 32'd0);
        for (int n = 0; n < side_ops; n++) random_op();
        read_reg(fetch_pkg::reg_ctrl, "cfg_rdata ctrl", 32'd1);
        read_reg(fetch_pkg::reg_demand_count, "cfg_rdata demand_count", demand_total);
        read_reg(fetch_pkg::reg_prefetch_count, "cfg_rdata prefetch_count", prefetch_total);
        end_test("statistics_counters");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // 40 cycles of 40 ns per operation plus margin
    initial begin
        #watchdog_ns;
        $display("watchdog expired before the tests completed");
        $display("Something failed");
        $finish;
    end

endmodule

// ==== verif/mem_model.sv ====
`timescale 1ns/100ps

module mem_model (
    input  logic                clk,
    input  logic                rst,
    input  fetch_pkg::mem_req_t mem_req,
    output logic                mem_resp,
    output fetch_pkg::line_t    mem_rdata
);

    logic [31:0] lcg_state;
    logic        busy;
    logic [3:0]  remaining;
    logic [31:0] addr_q;

    function automatic logic [31:0] advance_lcg(input logic [31:0] value);
        return value * 32'd1664525 + 32'd1013904223;
    endfunction

    // every word is its own byte address xor a fixed pattern
    function automatic fetch_pkg::line_t line_pattern(input logic [31:0] address);
        fetch_pkg::line_t line;
        logic [31:0]      base;
        base = {address[31:fetch_pkg::offset_bits], {fetch_pkg::offset_bits{1'b0}}};
        for (int w = 0; w < fetch_pkg::line_bits / 32; w++) begin
            line[32*w +: 32] = (base + 32'(4 * w)) ^ 32'ha5a5a5a5;
        end
        return line;
    endfunction

    initial begin
        lcg_state = 32'h9df5;
        mem_resp  = 1'b0;
        mem_rdata = '0;
        busy      = 1'b0;
        remaining = '0;
        addr_q    = '0;
    end

    // outputs change on the falling edge
    always @(negedge clk) begin
        mem_resp <= 1'b0;
        if (rst) begin
            busy <= 1'b0;
        end else if (busy) begin
            if (remaining == 4'd1) begin
                mem_resp  <= 1'b1;
                mem_rdata <= line_pattern(addr_q);
                busy      <= 1'b0;
            end else begin
                remaining <= remaining - 4'd1;
            end
        end else if (mem_req.read && !mem_resp) begin
            // latency of 2 to 9 cycles
            lcg_state <= advance_lcg(lcg_state);
            remaining <= 4'd2 + {1'b0, lcg_state[18:16]};
            addr_q    <= mem_req.address;
            busy      <= 1'b1;
        end
    end

endmodule
